//--- Makefile
SIM      := verilator
TOP      := tb_udp_core
FILELIST := build.f
FLAGS    := --binary --timing --assert --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) common/udp_defines.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+common
common/udp_pkg.sv
common/word_stream_if.sv
design/word_fifo.sv
rx/udp_rx_parser.sv
tx/udp_tx_framer.sv
design/udp_core_top.sv
verif/tb_udp_core.sv

//--- common/udp_defines.svh
`ifndef UDP_DEFINES_SVH
`define UDP_DEFINES_SVH

// Stream geometry
`define UDP_DATA_WIDTH 32
`define UDP_KEEP_WIDTH 4

// Own addresses with the most significant byte sent first
`define UDP_SELF_MAC 48'h02_00_00_00_00_01
`define UDP_SELF_IP 32'hc0_a8_00_01

// Protocol constants
`define UDP_ETHERTYPE_IPV4 16'h0800
`define UDP_IP_VER_IHL 8'h45
`define UDP_IP_PROTO_UDP 8'd17
`define UDP_IP_TTL 8'h80

// Header sizes in bytes
`define UDP_HDR_BYTES 16'd42
`define UDP_IP_UDP_BYTES 16'd28
`define UDP_UDP_HDR_BYTES 16'd8

`define UDP_FIFO_DEPTH 64

`endif

//--- common/udp_pkg.sv
`include "udp_defines.svh"

package udp_pkg;

    typedef logic [`UDP_DATA_WIDTH-1:0] data_word_t;
    typedef logic [`UDP_KEEP_WIDTH-1:0] byte_keep_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] byte_count_t;

    // Lane 0 lands in the top byte so header fields read in wire order
    function automatic data_word_t byte_swap(data_word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Lane enables for the bytes still due in this word
    function automatic byte_keep_t keep_for(byte_count_t n);
        byte_keep_t k;
        case (n)
            16'd0:   k = 4'b0000;
            16'd1:   k = 4'b0001;
            16'd2:   k = 4'b0011;
            16'd3:   k = 4'b0111;
            default: k = 4'b1111;
        endcase
        return k;
    endfunction

endpackage

//--- common/word_stream_if.sv
`timescale 1ns/1ps

interface word_stream_if
    import udp_pkg::*;
();

    data_word_t data;
    byte_keep_t keep;
    logic       last;
    logic       valid;
    logic       ready;

    modport source (output data, output keep, output last, output valid, input ready);
    modport sink (input data, input keep, input last, input valid, output ready);

endinterface

//--- design/udp_core_top.sv
`timescale 1ns/1ps
`include "udp_defines.svh"

module udp_core_top
    import udp_pkg::*;
(
    input  logic        ctrl_aclk,
    input  logic        ctrl_aresetn,
    input  data_word_t  eth_rx_data,
    input  byte_keep_t  eth_rx_keep,
    input  logic        eth_rx_last,
    input  logic        eth_rx_valid,
    output logic        eth_rx_ready,
    output data_word_t  eth_tx_data,
    output byte_keep_t  eth_tx_keep,
    output logic        eth_tx_last,
    output logic        eth_tx_valid,
    input  logic        eth_tx_ready,
    input  logic        tx_req_valid,
    output logic        tx_req_ready,
    input  mac_addr_t   tx_req_dst_mac,
    input  ipv4_addr_t  tx_req_dst_ip,
    input  udp_port_t   tx_req_src_port,
    input  udp_port_t   tx_req_dst_port,
    input  byte_count_t tx_req_length,
    input  data_word_t  tx_data_data,
    input  byte_keep_t  tx_data_keep,
    input  logic        tx_data_last,
    input  logic        tx_data_valid,
    output data_word_t  rx_payload_data,
    output byte_keep_t  rx_payload_keep,
    output logic        rx_payload_last,
    output logic        rx_payload_valid,
    input  logic        rx_payload_ready
);

    word_stream_if rx_payload ();
    word_stream_if rx_out ();
    word_stream_if tx_in ();
    word_stream_if tx_payload ();

    udp_rx_parser rx_parser (
        .ctrl_aclk    (ctrl_aclk),
        .ctrl_aresetn (ctrl_aresetn),
        .eth_rx_data  (eth_rx_data),
        .eth_rx_keep  (eth_rx_keep),
        .eth_rx_last  (eth_rx_last),
        .eth_rx_valid (eth_rx_valid),
        .eth_rx_ready (eth_rx_ready),
        .payload      (rx_payload)
    );

    word_fifo #(.DEPTH(`UDP_FIFO_DEPTH)) rx_fifo (
        .ctrl_aclk    (ctrl_aclk),
        .ctrl_aresetn (ctrl_aresetn),
        .wr           (rx_payload),
        .rd           (rx_out)
    );

    assign rx_payload_data  = rx_out.data;
    assign rx_payload_keep  = rx_out.keep;
    assign rx_payload_last  = rx_out.last;
    assign rx_payload_valid = rx_out.valid;
    assign rx_out.ready     = rx_payload_ready;

    // Transmit payload arrives as a plain write strobe and its ready goes nowhere
    assign tx_in.data  = tx_data_data;
    assign tx_in.keep  = tx_data_keep;
    assign tx_in.last  = tx_data_last;
    assign tx_in.valid = tx_data_valid;

    word_fifo #(.DEPTH(`UDP_FIFO_DEPTH)) tx_fifo (
        .ctrl_aclk    (ctrl_aclk),
        .ctrl_aresetn (ctrl_aresetn),
        .wr           (tx_in),
        .rd           (tx_payload)
    );

    udp_tx_framer tx_framer (
        .ctrl_aclk       (ctrl_aclk),
        .ctrl_aresetn    (ctrl_aresetn),
        .tx_req_valid    (tx_req_valid),
        .tx_req_ready    (tx_req_ready),
        .tx_req_dst_mac  (tx_req_dst_mac),
        .tx_req_dst_ip   (tx_req_dst_ip),
        .tx_req_src_port (tx_req_src_port),
        .tx_req_dst_port (tx_req_dst_port),
        .tx_req_length   (tx_req_length),
        .payload         (tx_payload),
        .eth_tx_data     (eth_tx_data),
        .eth_tx_keep     (eth_tx_keep),
        .eth_tx_last     (eth_tx_last),
        .eth_tx_valid    (eth_tx_valid),
        .eth_tx_ready    (eth_tx_ready)
    );

endmodule

//--- design/word_fifo.sv
`timescale 1ns/1ps
`include "udp_defines.svh"

module word_fifo
    import udp_pkg::*;
#(
    parameter int DEPTH = `UDP_FIFO_DEPTH
) (
    input  logic          ctrl_aclk,
    input  logic          ctrl_aresetn,
    word_stream_if.sink   wr,
    word_stream_if.source rd
);

    localparam int PTR_W = $clog2(DEPTH);

    data_word_t       mem_data [DEPTH];
    byte_keep_t       mem_keep [DEPTH];
    logic             mem_last [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_fire;
    logic             rd_fire;

    assign wr.ready = (count != (PTR_W + 1)'(DEPTH));
    assign rd.valid = (count != '0);
    assign wr_fire  = wr.valid && wr.ready;
    assign rd_fire  = rd.valid && rd.ready;

    // Head of the buffer is presented directly
    assign rd.data = mem_data[rd_ptr];
    assign rd.keep = mem_keep[rd_ptr];
    assign rd.last = mem_last[rd_ptr];

    always_ff @(posedge ctrl_aclk) begin
        if (wr_fire) begin
            mem_data[wr_ptr] <= wr.data;
            mem_keep[wr_ptr] <= wr.keep;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    always_ff @(posedge ctrl_aclk) begin
        if (!ctrl_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A word offered while full must still be offered, unchanged, one cycle later
    assert property (@(posedge ctrl_aclk) disable iff (!ctrl_aresetn)
        (wr.valid && !wr.ready) |=> (wr.valid && $stable(wr.data)))
        else $error("word_fifo: write while full lost a word");

endmodule

//--- rx/udp_rx_parser.sv
`timescale 1ns/1ps
`include "udp_defines.svh"

module udp_rx_parser
    import udp_pkg::*;
(
    input  logic          ctrl_aclk,
    input  logic          ctrl_aresetn,
    input  data_word_t    eth_rx_data,
    input  byte_keep_t    eth_rx_keep,
    input  logic          eth_rx_last,
    input  logic          eth_rx_valid,
    output logic          eth_rx_ready,
    word_stream_if.source payload
);

    typedef enum logic [1:0] {S_HDR, S_PAY, S_FLUSH, S_DRAIN} state_t;

    state_t      state;
    logic [3:0]  beat;
    data_word_t  rx_be;
    mac_addr_t   dst_mac;
    ipv4_addr_t  dst_ip;
    logic [15:0] ethertype;
    logic [7:0]  ver_ihl;
    logic [7:0]  proto;
    byte_count_t udp_len;
    byte_count_t rem;
    logic [15:0] hold;
    logic        accept;
    logic        rx_fire;

    assign rx_be   = byte_swap(eth_rx_data);
    assign udp_len = rx_be[15:0];

    // All filter fields are in by header word 9
    assign accept = (dst_mac == `UDP_SELF_MAC) && (dst_ip == `UDP_SELF_IP)
                 && (ethertype == `UDP_ETHERTYPE_IPV4) && (ver_ihl == `UDP_IP_VER_IHL)
                 && (proto == `UDP_IP_PROTO_UDP);

    always_comb begin
        case (state)
            S_PAY:   eth_rx_ready = (rem == '0) || payload.ready;
            S_FLUSH: eth_rx_ready = 1'b0;
            default: eth_rx_ready = 1'b1;
        endcase
    end

    assign rx_fire = eth_rx_valid && eth_rx_ready;

    // Payload shifted down two lanes by pairing the held upper half with the new lower half
    assign payload.valid = (state == S_FLUSH)
                        || ((state == S_PAY) && eth_rx_valid && (rem != '0));
    assign payload.data  = (state == S_FLUSH) ? {16'h0000, hold} : {eth_rx_data[15:0], hold};
    assign payload.keep  = (state == S_FLUSH) ? keep_for((rem > 16'd2) ? 16'd2 : rem)
                                              : keep_for(rem);
    assign payload.last  = (state == S_FLUSH) || (rem <= 16'd4);

    always_ff @(posedge ctrl_aclk) begin
        if (!ctrl_aresetn) begin
            state <= S_HDR;
            beat  <= '0;
        end else begin
            case (state)
                S_HDR: begin
                    if (rx_fire) begin
                        beat <= beat + 4'd1;
                        if ((beat == 4'd9) && !accept) begin
                            state <= S_DRAIN;
                        end
                        if (beat == 4'd10) begin
                            state <= S_PAY;
                        end
                        // Frame ending inside the header, or payload only in the held half
                        if (eth_rx_last) begin
                            state <= ((beat == 4'd10) && (rem != '0)) ? S_FLUSH : S_HDR;
                        end
                    end
                end
                S_PAY: begin
                    if (rx_fire && eth_rx_last) begin
                        state <= (rem > 16'd4) ? S_FLUSH : S_HDR;
                    end
                end
                S_FLUSH: begin
                    if (payload.ready) begin
                        state <= S_HDR;
                    end
                end
                default: begin
                    if (rx_fire && eth_rx_last) begin
                        state <= S_HDR;
                    end
                end
            endcase
            if (rx_fire && eth_rx_last) begin
                beat <= '0;
            end
        end
    end

    // Field capture per header beat, then the payload shift
    always_ff @(posedge ctrl_aclk) begin
        if (rx_fire) begin
            if (state == S_HDR) begin
                case (beat)
                    4'd0: dst_mac[47:16] <= rx_be;
                    4'd1: dst_mac[15:0] <= rx_be[31:16];
                    4'd3: begin
                        ethertype <= rx_be[31:16];
                        ver_ihl   <= rx_be[15:8];
                    end
                    4'd5:  proto <= rx_be[7:0];
                    4'd7:  dst_ip[31:16] <= rx_be[15:0];
                    4'd8:  dst_ip[15:0] <= rx_be[31:16];
                    4'd9:  rem <= udp_len - `UDP_UDP_HDR_BYTES;
                    4'd10: hold <= eth_rx_data[31:16];
                    default: ;
                endcase
            end else if (state == S_PAY) begin
                hold <= eth_rx_data[31:16];
                rem  <= (rem > 16'd4) ? rem - 16'd4 : '0;
            end
        end
    end

    assert property (@(posedge ctrl_aclk) disable iff (!ctrl_aresetn)
        eth_rx_valid |-> (eth_rx_keep != '0))
        else $error("udp_rx_parser: valid input word with empty keep");

endmodule

//--- tx/udp_tx_framer.sv
`timescale 1ns/1ps
`include "udp_defines.svh"

module udp_tx_framer
    import udp_pkg::*;
(
    input  logic        ctrl_aclk,
    input  logic        ctrl_aresetn,
    input  logic        tx_req_valid,
    output logic        tx_req_ready,
    input  mac_addr_t   tx_req_dst_mac,
    input  ipv4_addr_t  tx_req_dst_ip,
    input  udp_port_t   tx_req_src_port,
    input  udp_port_t   tx_req_dst_port,
    input  byte_count_t tx_req_length,
    word_stream_if.sink payload,
    output data_word_t  eth_tx_data,
    output byte_keep_t  eth_tx_keep,
    output logic        eth_tx_last,
    output logic        eth_tx_valid,
    input  logic        eth_tx_ready
);

    localparam mac_addr_t  SELF_MAC = `UDP_SELF_MAC;
    localparam ipv4_addr_t SELF_IP  = `UDP_SELF_IP;

    typedef enum logic [1:0] {S_IDLE, S_CSUM, S_SEND} state_t;

    state_t      state;
    mac_addr_t   dst_mac;
    ipv4_addr_t  dst_ip;
    udp_port_t   src_port;
    udp_port_t   dst_port;
    byte_count_t length;
    byte_count_t ip_len;
    byte_count_t udp_len;
    logic [3:0]  idx;
    logic [15:0] hw;
    logic [16:0] hw_sum;
    logic [15:0] csum_fold;
    logic [15:0] csum_acc;
    logic [15:0] csum;
    logic [3:0]  wcnt;
    byte_count_t rem;
    byte_count_t pay_left;
    logic [15:0] hold;
    data_word_t  hdr_be;
    logic        in_payload;
    logic        need_word;
    logic        tx_fire;

    assign ip_len       = length + `UDP_IP_UDP_BYTES;
    assign udp_len      = length + `UDP_UDP_HDR_BYTES;
    assign tx_req_ready = (state == S_IDLE);

    // IP header halfwords in wire order with the checksum field as zero
    always_comb begin
        case (idx)
            4'd0:    hw = {`UDP_IP_VER_IHL, 8'h00};
            4'd1:    hw = ip_len;
            4'd4:    hw = {`UDP_IP_TTL, `UDP_IP_PROTO_UDP};
            4'd6:    hw = SELF_IP[31:16];
            4'd7:    hw = SELF_IP[15:0];
            4'd8:    hw = dst_ip[31:16];
            4'd9:    hw = dst_ip[15:0];
            default: hw = 16'h0000;
        endcase
    end

    // Ones-complement add with end-around carry
    assign hw_sum    = {1'b0, csum_acc} + {1'b0, hw};
    assign csum_fold = hw_sum[15:0] + {15'd0, hw_sum[16]};

    always_comb begin
        case (wcnt)
            4'd0:    hdr_be = dst_mac[47:16];
            4'd1:    hdr_be = {dst_mac[15:0], SELF_MAC[47:32]};
            4'd2:    hdr_be = SELF_MAC[31:0];
            4'd3:    hdr_be = {`UDP_ETHERTYPE_IPV4, `UDP_IP_VER_IHL, 8'h00};
            4'd4:    hdr_be = {ip_len, 16'h0000};
            4'd5:    hdr_be = {16'h0000, `UDP_IP_TTL, `UDP_IP_PROTO_UDP};
            4'd6:    hdr_be = {csum, SELF_IP[31:16]};
            4'd7:    hdr_be = {SELF_IP[15:0], dst_ip[31:16]};
            4'd8:    hdr_be = {dst_ip[15:0], src_port};
            default: hdr_be = {dst_port, udp_len};
        endcase
    end

    // Word 10 onwards carries payload behind the zero UDP checksum
    assign in_payload = (wcnt == 4'd10);
    assign need_word  = in_payload && (pay_left != '0);

    assign eth_tx_valid  = (state == S_SEND) && (!need_word || payload.valid);
    assign eth_tx_data   = in_payload
                         ? {(need_word ? payload.data[15:0] : 16'h0000), hold}
                         : byte_swap(hdr_be);
    assign eth_tx_keep   = keep_for(rem);
    assign eth_tx_last   = (rem <= 16'd4);
    assign payload.ready = (state == S_SEND) && need_word && eth_tx_ready;
    assign tx_fire       = eth_tx_valid && eth_tx_ready;

    always_ff @(posedge ctrl_aclk) begin
        if (!ctrl_aresetn) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (tx_req_valid) begin
                        state <= S_CSUM;
                    end
                end
                S_CSUM: begin
                    if (idx == 4'd9) begin
                        state <= S_SEND;
                    end
                end
                default: begin
                    if (tx_fire && eth_tx_last) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge ctrl_aclk) begin
        case (state)
            S_IDLE: begin
                if (tx_req_valid) begin
                    dst_mac  <= tx_req_dst_mac;
                    dst_ip   <= tx_req_dst_ip;
                    src_port <= tx_req_src_port;
                    dst_port <= tx_req_dst_port;
                    length   <= tx_req_length;
                    idx      <= '0;
                    csum_acc <= '0;
                end
            end
            S_CSUM: begin
                idx      <= idx + 4'd1;
                csum_acc <= csum_fold;
                csum     <= ~csum_fold;
                wcnt     <= '0;
                rem      <= length + `UDP_HDR_BYTES;
                pay_left <= length;
                hold     <= 16'h0000;
            end
            default: begin
                if (tx_fire) begin
                    rem <= (rem > 16'd4) ? rem - 16'd4 : '0;
                    if (!in_payload) begin
                        wcnt <= wcnt + 4'd1;
                    end
                    if (need_word) begin
                        hold     <= payload.data[31:16];
                        pay_left <= (pay_left > 16'd4) ? pay_left - 16'd4 : '0;
                    end
                end
            end
        endcase
    end

    assert property (@(posedge ctrl_aclk) disable iff (!ctrl_aresetn)
        (eth_tx_valid && !eth_tx_ready)
        |=> ($stable(eth_tx_data) && $stable(eth_tx_keep) && $stable(eth_tx_last)))
        else $error("udp_tx_framer: output changed while stalled");

endmodule

//--- verif/tb_udp_core.sv
`timescale 1ns/1ps
`include "udp_defines.svh"

module tb_udp_core;
    import udp_pkg::*;

    localparam int TIMEOUT = 2000;

    logic        ctrl_aclk;
    logic        ctrl_aresetn;
    data_word_t  eth_rx_data;
    byte_keep_t  eth_rx_keep;
    logic        eth_rx_last;
    logic        eth_rx_valid;
    logic        eth_rx_ready;
    data_word_t  eth_tx_data;
    byte_keep_t  eth_tx_keep;
    logic        eth_tx_last;
    logic        eth_tx_valid;
    logic        eth_tx_ready;
    logic        tx_req_valid;
    logic        tx_req_ready;
    mac_addr_t   tx_req_dst_mac;
    ipv4_addr_t  tx_req_dst_ip;
    udp_port_t   tx_req_src_port;
    udp_port_t   tx_req_dst_port;
    byte_count_t tx_req_length;
    data_word_t  tx_data_data;
    byte_keep_t  tx_data_keep;
    logic        tx_data_last;
    logic        tx_data_valid;
    data_word_t  rx_payload_data;
    byte_keep_t  rx_payload_keep;
    logic        rx_payload_last;
    logic        rx_payload_valid;
    logic        rx_payload_ready;

    integer     seed;
    logic [7:0] build_q[$];
    logic [7:0] rx_frame_q[$];
    int         rx_len_q[$];
    logic [7:0] exp_pay_q[$];
    int         exp_len_q[$];
    logic [7:0] tx_frame_q[$];
    logic [7:0] tx_pay_q[$];
    logic       saw_stall;
    int         i;

    udp_core_top uut (.*);

    initial ctrl_aclk = 1'b0;
    always #50 ctrl_aclk = ~ctrl_aclk;

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic step();
        @(posedge ctrl_aclk);
        #1;
    endtask

    function automatic byte_keep_t keep_of(input int n);
        byte_keep_t k;
        for (int l = 0; l < 4; l++) begin
            k[l] = (l < n);
        end
        return k;
    endfunction

    function automatic data_word_t lane_mask(input byte_keep_t k);
        data_word_t m;
        for (int l = 0; l < 4; l++) begin
            m[8*l +: 8] = k[l] ? 8'hff : 8'h00;
        end
        return m;
    endfunction

    task automatic check_payload_word(input data_word_t got, input data_word_t exp,
                                      input byte_keep_t got_keep, input byte_keep_t exp_keep,
                                      input logic got_last, input logic exp_last);
        if (got_keep !== exp_keep || got_last !== exp_last) begin
            report_mismatch($sformatf("rx payload keep/last %h/%b, expected %h/%b",
                                      got_keep, got_last, exp_keep, exp_last));
        end
        if ((got & lane_mask(exp_keep)) !== (exp & lane_mask(exp_keep))) begin
            report_mismatch($sformatf("rx payload data %h, expected %h", got, exp));
        end
    endtask

    task automatic check_frame_word(input data_word_t got, input data_word_t exp,
                                    input byte_keep_t got_keep, input byte_keep_t exp_keep,
                                    input logic got_last, input logic exp_last);
        if (got_keep !== exp_keep || got_last !== exp_last) begin
            report_mismatch($sformatf("tx frame keep/last %h/%b, expected %h/%b",
                                      got_keep, got_last, exp_keep, exp_last));
        end
        if ((got & lane_mask(exp_keep)) !== (exp & lane_mask(exp_keep))) begin
            report_mismatch($sformatf("tx frame data %h, expected %h", got, exp));
        end
    endtask

    task automatic check_idle(input logic got, input string name);
        if (got !== 1'b0) begin
            report_mismatch($sformatf("%s is high while it should be idle", name));
        end
    endtask

    // Big-endian field with the most significant byte first on the wire
    task automatic push_field(input logic [47:0] v, input int n);
        for (int b = n - 1; b >= 0; b--) begin
            build_q.push_back(v[8*b +: 8]);
        end
    endtask

    function automatic logic [47:0] rnd48();
        return {16'($random(seed)), 32'($random(seed))};
    endfunction

    // Rule 0 builds a good frame and rules 1 to 5 break one filter each
    task automatic build_rx_frame(input int rule, input int len);
        logic [47:0] mac;
        logic [31:0] ip;
        logic [15:0] etype;
        logic [7:0]  ver;
        logic [7:0]  proto;
        mac   = `UDP_SELF_MAC;
        ip    = `UDP_SELF_IP;
        etype = 16'h0800;
        ver   = 8'h45;
        proto = 8'd17;
        case (rule)
            1: etype = 16'h86dd;
            2: ver = 8'h46;
            3: mac = mac ^ 48'h1;
            4: ip = ip ^ 32'h100;
            5: proto = 8'd6;
            default: ;
        endcase
        build_q.delete();
        push_field(mac, 6);
        push_field(rnd48(), 6);
        push_field(48'(etype), 2);
        push_field(48'(ver), 1);
        push_field(48'h0, 1);
        push_field(48'(len + 28), 2);
        push_field(rnd48(), 4);
        push_field(48'h40, 1);
        push_field(48'(proto), 1);
        push_field(rnd48(), 2);
        push_field(rnd48(), 4);
        push_field(48'(ip), 4);
        push_field(rnd48(), 4);
        push_field(48'(len + 8), 2);
        push_field(48'h0, 2);
        for (int b = 0; b < len; b++) begin
            build_q.push_back(8'($random(seed)));
            if (rule == 0) begin
                exp_pay_q.push_back(build_q[build_q.size() - 1]);
            end
        end
        if (rule == 0) begin
            exp_len_q.push_back(len);
        end
        rx_len_q.push_back(build_q.size());
        foreach (build_q[b]) begin
            rx_frame_q.push_back(build_q[b]);
        end
    endtask

    task automatic drive_rx_frames();
        int  n;
        int  t;
        int  streak;
        int  gap;
        logic fire;
        streak = 0;
        while (rx_len_q.size() > 0) begin
            n = rx_len_q.pop_front();
            for (int w = 0; w < n; w += 4) begin
                eth_rx_data = '0;
                for (int k = 0; k < 4; k++) begin
                    if (w + k < n) begin
                        eth_rx_data[8*k +: 8] = rx_frame_q.pop_front();
                    end
                end
                eth_rx_keep  = keep_of(n - w);
                eth_rx_last  = (w + 4 >= n);
                eth_rx_valid = 1'b1;
                t = 0;
                do begin
                    @(negedge ctrl_aclk);
                    fire   = eth_rx_ready;
                    streak = fire ? 0 : streak + 1;
                    // A long stall means the receive buffer filled up
                    if (streak >= 3) begin
                        saw_stall = 1'b1;
                    end
                    step();
                    t++;
                    if (t > TIMEOUT) begin
                        report_timeout("eth_rx_ready");
                    end
                end while (!fire);
                eth_rx_valid = 1'b0;
            end
            gap = {$random(seed)} % 4;
            repeat (gap) step();
        end
    endtask

    task automatic receive_payloads(input bit random_ready, input int hold_off);
        int          len;
        int          got;
        int          n;
        int          t;
        data_word_t  exp_w;
        logic        fire;
        while (exp_len_q.size() > 0) begin
            len  = exp_len_q.pop_front();
            got  = 0;
            while (got < len) begin
                n     = (len - got > 4) ? 4 : len - got;
                exp_w = '0;
                for (int k = 0; k < n; k++) begin
                    exp_w[8*k +: 8] = exp_pay_q.pop_front();
                end
                t = 0;
                do begin
                    if (hold_off > 0) begin
                        rx_payload_ready = 1'b0;
                        hold_off--;
                    end else begin
                        rx_payload_ready = random_ready ? ({$random(seed)} % 3 != 0) : 1'b1;
                    end
                    @(negedge ctrl_aclk);
                    fire = rx_payload_valid && rx_payload_ready;
                    if (fire) begin
                        check_payload_word(rx_payload_data, exp_w, rx_payload_keep,
                                           keep_of(n), rx_payload_last, (got + n == len));
                    end
                    step();
                    t++;
                    if (t > TIMEOUT) begin
                        report_timeout("rx_payload_valid");
                    end
                end while (!fire);
                got += n;
            end
        end
        rx_payload_ready = 1'b1;
    endtask

    // Request fields, IP checksum and the whole expected frame
    task automatic build_tx(input int len);
        logic [15:0] hw [9];
        logic [31:0] sum;
        logic [15:0] csum;
        tx_req_dst_mac  = rnd48();
        tx_req_dst_ip   = 32'($random(seed));
        tx_req_src_port = 16'($random(seed));
        tx_req_dst_port = 16'($random(seed));
        tx_req_length   = byte_count_t'(len);
        hw = '{16'h4500, 16'(len + 28), 16'h0, 16'h0, 16'h8011, 16'hc0a8, 16'h0001,
               tx_req_dst_ip[31:16], tx_req_dst_ip[15:0]};
        sum = '0;
        foreach (hw[h]) begin
            sum = sum + {16'h0, hw[h]};
        end
        while (sum[31:16] != 16'h0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        csum = ~sum[15:0];
        build_q.delete();
        push_field(tx_req_dst_mac, 6);
        push_field(`UDP_SELF_MAC, 6);
        push_field(48'h0800, 2);
        push_field(48'h4500, 2);
        push_field(48'(len + 28), 2);
        push_field(48'h0, 4);
        push_field(48'h8011, 2);
        push_field(48'(csum), 2);
        push_field(48'(`UDP_SELF_IP), 4);
        push_field(48'(tx_req_dst_ip), 4);
        push_field(48'(tx_req_src_port), 2);
        push_field(48'(tx_req_dst_port), 2);
        push_field(48'(len + 8), 2);
        push_field(48'h0, 2);
        tx_pay_q.delete();
        for (int b = 0; b < len; b++) begin
            tx_pay_q.push_back(8'($random(seed)));
            build_q.push_back(tx_pay_q[b]);
        end
        tx_frame_q = build_q;
    endtask

    task automatic write_payload();
        int n;
        n = tx_pay_q.size();
        for (int w = 0; w < n; w += 4) begin
            tx_data_data = '0;
            for (int k = 0; k < 4; k++) begin
                if (w + k < n) begin
                    tx_data_data[8*k +: 8] = tx_pay_q[w + k];
                end
            end
            tx_data_keep  = keep_of(n - w);
            tx_data_last  = (w + 4 >= n);
            tx_data_valid = 1'b1;
            step();
        end
        tx_data_valid = 1'b0;
    endtask

    task automatic send_request();
        int   t;
        logic fire;
        tx_req_valid = 1'b1;
        t = 0;
        do begin
            @(negedge ctrl_aclk);
            fire = tx_req_ready;
            step();
            t++;
            if (t > TIMEOUT) begin
                report_timeout("tx_req_ready");
            end
        end while (!fire);
        tx_req_valid = 1'b0;
    endtask

    task automatic collect_frame(input bit random_ready);
        int         n;
        int         t;
        data_word_t exp_w;
        logic       fire;
        n = tx_frame_q.size();
        for (int w = 0; w < n; w += 4) begin
            exp_w = '0;
            for (int k = 0; k < 4; k++) begin
                if (w + k < n) begin
                    exp_w[8*k +: 8] = tx_frame_q[w + k];
                end
            end
            t = 0;
            do begin
                eth_tx_ready = random_ready ? ({$random(seed)} % 2 == 0) : 1'b1;
                @(negedge ctrl_aclk);
                fire = eth_tx_valid && eth_tx_ready;
                if (fire) begin
                    check_frame_word(eth_tx_data, exp_w, eth_tx_keep, keep_of(n - w),
                                     eth_tx_last, (w + 4 >= n));
                end
                step();
                t++;
                if (t > TIMEOUT) begin
                    report_timeout("eth_tx_valid");
                end
            end while (!fire);
        end
        eth_tx_ready = 1'b1;
    endtask

    initial begin
        seed             = 32'h4d2a_51ad;
        saw_stall        = 1'b0;
        ctrl_aresetn     = 1'b0;
        eth_rx_data      = '0;
        eth_rx_keep      = '0;
        eth_rx_last      = 1'b0;
        eth_rx_valid     = 1'b0;
        eth_tx_ready     = 1'b1;
        tx_req_valid     = 1'b0;
        tx_req_dst_mac   = '0;
        tx_req_dst_ip    = '0;
        tx_req_src_port  = '0;
        tx_req_dst_port  = '0;
        tx_req_length    = '0;
        tx_data_data     = '0;
        tx_data_keep     = '0;
        tx_data_last     = 1'b0;
        tx_data_valid    = 1'b0;
        rx_payload_ready = 1'b1;

        repeat (3) begin
            step();
            check_idle(rx_payload_valid, "rx_payload_valid");
            check_idle(eth_tx_valid, "eth_tx_valid");
        end
        ctrl_aresetn = 1'b1;
        @(negedge ctrl_aclk);
        check_idle(rx_payload_valid, "rx_payload_valid");
        check_idle(eth_tx_valid, "eth_tx_valid");
        check_idle(!tx_req_ready, "not tx_req_ready");
        step();

        // One good frame, then good and filtered frames mixed
        build_rx_frame(0, 1 + {$random(seed)} % 200);
        for (i = 0; i < 12; i++) begin
            build_rx_frame((i % 2 == 0) ? 0 : 1 + {$random(seed)} % 5, 1 + {$random(seed)} % 200);
        end
        fork
            drive_rx_frames();
            receive_payloads(1'b0, 0);
        join
        repeat (20) step();
        check_idle(rx_payload_valid, "rx_payload_valid after the last good frame");

        // Sink held off long enough to fill the receive buffer
        for (i = 0; i < 8; i++) begin
            build_rx_frame(0, 1 + {$random(seed)} % 200);
        end
        fork
            drive_rx_frames();
            receive_payloads(1'b1, 300);
        join
        if (!saw_stall) begin
            $display("eth_rx_ready never dropped while the receive buffer was full");
            $display("Finished with errors");
            $fatal(1, "no back-pressure seen");
        end

        for (i = 0; i < 3; i++) begin
            build_tx(1 + {$random(seed)} % 200);
            write_payload();
            send_request();
            collect_frame(1'b0);
        end
        for (i = 0; i < 3; i++) begin
            build_tx(1 + {$random(seed)} % 200);
            send_request();
            fork
                write_payload();
                collect_frame(1'b1);
            join
        end

        repeat (5) step();
        $display("Finished with no errors");
        $finish;
    end

endmodule
